//--- sim.f
src/conv_pkg.sv
src/buffer_sram.sv
src/buffer_wrapper.sv
src/addr_counter.sv
src/epu_ctrl.sv
src/conv3_datapath.sv
src/conv_acc_top.sv
bench/tb_conv_acc.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_conv_acc -f sim.f -o vsim

run: compile
	@out=$$(./obj_dir/vsim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- bench/tb_conv_acc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_acc;

  typedef struct packed {
    conv_pkg::addr_t   len;
    conv_pkg::weight_t w0;
    conv_pkg::weight_t w1;
    conv_pkg::weight_t w2;
    logic              big;    // large positive samples
    logic              fixed;  // every result equals exp
    conv_pkg::data_t   exp;
  } case_t;

  localparam int NUM_CASES = 5;
  localparam logic [31:0] LFSR_SEED = 32'hd6ff_8fc7;
  localparam case_t CASES [NUM_CASES] = '{
    '{10'd12,  8'sd3,   -8'sd5,   8'sd7,   1'b0, 1'b0, 16'sd0},     // mixed signs
    '{10'd20,  8'sd100,  8'sd90,  8'sd120, 1'b1, 1'b1, 16'sd32767}, // saturates
    '{10'd16, -8'sd50,  -8'sd60, -8'sd70,  1'b1, 1'b1, 16'sd0},     // relu clip
    '{10'd3,  -8'sd2,    8'sd9,   8'sd4,   1'b0, 1'b0, 16'sd0},     // single result
    '{10'd24,  8'sd11,  -8'sd13,  8'sd6,   1'b0, 1'b0, 16'sd0}
  };

  logic clk = 1'b0;
  logic rst;
  logic host_rd_req, host_wr_req, host_fin, host_sel, host_cs, host_oe;
  conv_pkg::addr_t   host_addr;
  conv_pkg::data_t   host_wdata;
  conv_pkg::data_t   host_rdata;
  logic              host_rvalid;
  logic              start;
  conv_pkg::addr_t   len;
  conv_pkg::weight_t w0, w1, w2;
  logic              done;

  conv_pkg::data_t samples [conv_pkg::BUF_DEPTH];
  conv_pkg::data_t exp_buf [conv_pkg::BUF_DEPTH];
  logic [31:0]     lfsr_q;
  int              errors;
  int              checks;

  conv_acc_top UUT (
    .clk (clk), .rst (rst),
    .host_rd_req_i (host_rd_req), .host_wr_req_i (host_wr_req),
    .host_fin_i    (host_fin),    .host_sel_i    (host_sel),
    .host_cs_i     (host_cs),     .host_oe_i     (host_oe),
    .host_addr_i   (host_addr),   .host_wdata_i  (host_wdata),
    .host_rdata_o  (host_rdata),  .host_rvalid_o (host_rvalid),
    .start_i (start), .len_i (len),
    .w0_i (w0), .w1_i (w1), .w2_i (w2),
    .done_o (done)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32,22,2,1
  endfunction

  task automatic next_sample(output conv_pkg::data_t v);
    for (int b = 0; b < 16; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[14:0], lfsr_q[0]};
    end
  endtask

  // reference model relu(sat(w0*x0 + w1*x1 + w2*x2))
  function automatic conv_pkg::data_t conv_model(input conv_pkg::data_t x0, x1, x2,
                                                 input conv_pkg::weight_t c0, c1, c2);
    int sum;
    sum = int'(c0) * int'(x0) + int'(c1) * int'(x1) + int'(c2) * int'(x2);
    if (sum > conv_pkg::DATA_MAX) return conv_pkg::data_t'(conv_pkg::DATA_MAX);
    if (sum < 0) return '0;
    return conv_pkg::data_t'(sum);
  endfunction

  task automatic check_data(input conv_pkg::data_t got, input conv_pkg::data_t exp,
                            input string msg);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic report(input string name, input int err_before);
    if (errors == err_before) $display("%s: pass", name);
    else $display("%s: fail, %0d errors", name, errors - err_before);
  endtask

  task automatic host_req(input logic sel, input logic rd, input logic wr, input logic fin);
    host_sel    = sel;
    host_rd_req = rd;
    host_wr_req = wr;
    host_fin    = fin;
    @(negedge clk);
    host_rd_req = 1'b0;
    host_wr_req = 1'b0;
    host_fin    = 1'b0;
  endtask

  task automatic write_words(input int n);
    for (int i = 0; i < n; i++) begin
      host_cs    = 1'b1;
      host_addr  = conv_pkg::addr_t'(i);
      host_wdata = samples[i];
      @(negedge clk);
    end
    host_cs = 1'b0;
  endtask

  // gap leaves an idle cycle after each read
  task automatic read_back(input int n, input logic gap);
    for (int i = 0; i < n; i++) begin
      host_cs   = 1'b1;
      host_oe   = 1'b1;
      host_addr = conv_pkg::addr_t'(i);
      @(negedge clk);
      if (gap) host_cs = 1'b0;
      check_flag(host_rvalid, 1'b1, $sformatf("rvalid for read %0d", i));
      check_data(host_rdata, exp_buf[i], $sformatf("read data at %0d", i));
      if (gap) begin
        @(negedge clk);
        check_flag(host_rvalid, 1'b0, "rvalid held past one cycle");
      end
    end
    host_cs = 1'b0;
    host_oe = 1'b0;
    @(negedge clk);
    check_flag(host_rvalid, 1'b0, "rvalid after last read");
  endtask

  task automatic run_engine(input case_t tc);
    int n;
    len   = tc.len;
    w0    = tc.w0;
    w1    = tc.w1;
    w2    = tc.w2;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    n = 1;
    while (!done && n < int'(tc.len) + 20) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      $display("done_o never came for a run of length %0d", tc.len);
      errors++;
    end else begin
      check_flag(n == int'(tc.len) + 3, 1'b1, $sformatf("done_o %0d cycles after start", n));
      @(negedge clk);
      check_flag(done, 1'b0, "done_o longer than one cycle");
    end
  endtask

  initial begin : watchdog
    int budget;
    budget = 0;
    for (int c = 0; c < NUM_CASES; c++) budget += 2 * int'(CASES[c].len) + 40;
    repeat (budget) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", budget);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    case_t cur;
    int    err0;
    rst = 1'b1;
    host_rd_req = 1'b0;
    host_wr_req = 1'b0;
    host_fin = 1'b0;
    host_sel = 1'b0;
    host_cs = 1'b0;
    host_oe = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    start = 1'b0;
    len = '0;
    w0 = '0;
    w1 = '0;
    w2 = '0;
    lfsr_q = LFSR_SEED;
    errors = 0;
    checks = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    host_cs = 1'b1;  // reads with no request granted
    host_oe = 1'b1;
    host_addr = conv_pkg::addr_t'(5);
    for (int s = 0; s < 2; s++) begin
      host_sel = logic'(s);
      @(negedge clk);
      check_flag(host_rvalid, 1'b0, "rvalid before any request");
      check_flag(done, 1'b0, "done_o after reset");
      check_data(host_rdata, '0, "read data before any request");
    end
    host_cs = 1'b0;
    host_oe = 1'b0;
    report("idle after reset", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      next_sample(samples[i]);
      exp_buf[i] = samples[i];
    end
    host_req(1'b0, 1'b0, 1'b1, 1'b0);
    write_words(6);
    host_req(1'b0, 1'b0, 1'b0, 1'b1);
    host_req(1'b0, 1'b1, 1'b0, 1'b0);
    read_back(6, 1'b1);
    host_req(1'b0, 1'b0, 1'b0, 1'b1);
    host_req(1'b1, 1'b1, 1'b0, 1'b0);  // output buffer to engine
    host_req(1'b1, 1'b0, 1'b0, 1'b1);
    report("host write and read back", err0);

    for (int c = 0; c < NUM_CASES; c++) begin
      cur = CASES[c];
      err0 = errors;
      for (int i = 0; i < int'(cur.len); i++) begin
        next_sample(samples[i]);
        if (cur.big) samples[i] = {2'b01, samples[i][13:0]};
      end
      for (int k = 0; k < int'(cur.len) - 2; k++) begin
        exp_buf[k] = cur.fixed ? cur.exp :
                     conv_model(samples[k], samples[k+1], samples[k+2], cur.w0, cur.w1, cur.w2);
      end
      host_req(1'b0, 1'b0, 1'b1, 1'b0);
      write_words(int'(cur.len));
      host_req(1'b0, 1'b0, 1'b0, 1'b1);
      run_engine(cur);
      host_req(1'b1, 1'b1, 1'b0, 1'b0);
      read_back(int'(cur.len) - 1, 1'b0);  // word past the results keeps its old value
      host_req(1'b1, 1'b0, 1'b0, 1'b1);
      report($sformatf("run %0d, len %0d", c, cur.len), err0);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/conv_acc_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_acc_top (
  input  wire logic              clk,
  input  wire logic              rst,
  // host port
  input  wire logic              host_rd_req_i,
  input  wire logic              host_wr_req_i,
  input  wire logic              host_fin_i,
  input  wire logic              host_sel_i,
  input  wire logic              host_cs_i,
  input  wire logic              host_oe_i,
  input  wire conv_pkg::addr_t   host_addr_i,
  input  wire conv_pkg::data_t   host_wdata_i,
  output conv_pkg::data_t        host_rdata_o,
  output logic                   host_rvalid_o,
  // run control
  input  wire logic              start_i,
  input  wire conv_pkg::addr_t   len_i,
  input  wire conv_pkg::weight_t w0_i,
  input  wire conv_pkg::weight_t w1_i,
  input  wire conv_pkg::weight_t w2_i,
  output logic                   done_o
);

  logic            in_enb;
  logic            out_enb;
  conv_pkg::data_t in_rdata;
  conv_pkg::data_t out_rdata;
  logic            in_rvalid;
  logic            out_rvalid;

  logic            rd_cs;
  conv_pkg::addr_t rd_addr;
  conv_pkg::data_t sample;
  logic            sample_valid;
  logic            result_valid;
  conv_pkg::data_t result;
  logic            wr_cs;
  conv_pkg::addr_t wr_addr;

  assign in_enb  = !host_sel_i;  // 0 selects input buffer
  assign out_enb = host_sel_i;

  // only the selected wrapper drives read data
  assign host_rdata_o  = in_rdata | out_rdata;
  assign host_rvalid_o = in_rvalid | out_rvalid;

  buffer_wrapper in_buf (
    .clk (clk), .rst (rst), .enb_i (in_enb),
    .host_rd_req_i (host_rd_req_i), .host_wr_req_i (host_wr_req_i),
    .host_fin_i    (host_fin_i),
    .host_cs_i     (host_cs_i),     .host_oe_i     (host_oe_i),
    .host_addr_i   (host_addr_i),   .host_wdata_i  (host_wdata_i),
    .rvalid_o      (in_rvalid),     .rdata_o       (in_rdata),
    .epu_cs_i      (rd_cs),         .epu_we_i      (1'b0),
    .epu_addr_i    (rd_addr),       .epu_wdata_i   ('0),
    .epu_rdata_o   (sample)
  );

  buffer_wrapper out_buf (
    .clk (clk), .rst (rst), .enb_i (out_enb),
    .host_rd_req_i (host_rd_req_i), .host_wr_req_i (host_wr_req_i),
    .host_fin_i    (host_fin_i),
    .host_cs_i     (host_cs_i),     .host_oe_i     (host_oe_i),
    .host_addr_i   (host_addr_i),   .host_wdata_i  (host_wdata_i),
    .rvalid_o      (out_rvalid),    .rdata_o       (out_rdata),
    .epu_cs_i      (wr_cs),         .epu_we_i      (1'b1),
    .epu_addr_i    (wr_addr),       .epu_wdata_i   (result),
    .epu_rdata_o   ()               // write-only for the engine
  );

  epu_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .start_i        (start_i),
    .len_i          (len_i),
    .rd_cs_o        (rd_cs),
    .rd_addr_o      (rd_addr),
    .sample_valid_o (sample_valid),
    .result_valid_i (result_valid),
    .wr_cs_o        (wr_cs),
    .wr_addr_o      (wr_addr),
    .done_o         (done_o)
  );

  conv3_datapath u_dp (
    .clk            (clk),
    .rst            (rst),
    .sample_valid_i (sample_valid),
    .sample_i       (sample),
    .w0_i           (w0_i),
    .w1_i           (w1_i),
    .w2_i           (w2_i),
    .clear_i        (start_i),  // new run empties the window
    .result_valid_o (result_valid),
    .result_o       (result)
  );

endmodule

`default_nettype wire

//--- src/conv3_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module conv3_datapath (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              sample_valid_i,
  input  wire conv_pkg::data_t   sample_i,
  input  wire conv_pkg::weight_t w0_i,
  input  wire conv_pkg::weight_t w1_i,
  input  wire conv_pkg::weight_t w2_i,
  input  wire logic              clear_i,
  output logic                   result_valid_o,
  output conv_pkg::data_t        result_o
);

  conv_pkg::data_t win0;  // x[k+1]
  conv_pkg::data_t win1;  // x[k]
  logic [1:0]      fill_cnt;
  logic            win_full;

  conv_pkg::acc_t  acc;
  conv_pkg::data_t relu;

  assign win_full = (fill_cnt == 2'd2);

  // window fill tracking
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      fill_cnt       <= 2'd0;
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= sample_valid_i && win_full;
      if (clear_i) begin
        fill_cnt <= 2'd0;
      end else if (sample_valid_i && !win_full) begin
        fill_cnt <= fill_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      win1 <= win0;
      win0 <= sample_i;
    end
    if (sample_valid_i && win_full) begin
      result_o <= relu;
    end
  end

  // incoming sample is x[k+2]
  assign acc = conv_pkg::acc_t'(w0_i) * conv_pkg::acc_t'(win1)
             + conv_pkg::acc_t'(w1_i) * conv_pkg::acc_t'(win0)
             + conv_pkg::acc_t'(w2_i) * conv_pkg::acc_t'(sample_i);

  always_comb begin
    if (acc > conv_pkg::acc_t'(conv_pkg::DATA_MAX)) begin
      relu = conv_pkg::data_t'(conv_pkg::DATA_MAX);  // saturate
    end else if (acc < 0) begin
      relu = '0;  // relu clip
    end else begin
      relu = acc[conv_pkg::DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- src/epu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module epu_ctrl (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            start_i,
  input  wire conv_pkg::addr_t len_i,
  // read side
  output logic                 rd_cs_o,
  output conv_pkg::addr_t      rd_addr_o,
  output logic                 sample_valid_o,
  // write side
  input  wire logic            result_valid_i,
  output logic                 wr_cs_o,
  output conv_pkg::addr_t      wr_addr_o,
  output logic                 done_o
);

  conv_pkg::epu_state_t state, next_state;

  conv_pkg::addr_t len_q;
  conv_pkg::addr_t wr_limit;
  logic            start_ok;
  logic            rd_last;
  logic            wr_last;

  assign start_ok = start_i && (state == conv_pkg::EPU_IDLE);
  assign wr_limit = len_q - conv_pkg::addr_t'(2);  // len-2 results

  addr_counter u_rd_cnt (
    .clk     (clk),
    .rst     (rst),
    .clear_i (start_ok),
    .step_i  (rd_cs_o),
    .limit_i (len_q),
    .count_o (rd_addr_o),
    .last_o  (rd_last)
  );

  addr_counter u_wr_cnt (
    .clk     (clk),
    .rst     (rst),
    .clear_i (start_ok),
    .step_i  (wr_cs_o),
    .limit_i (wr_limit),
    .count_o (wr_addr_o),
    .last_o  (wr_last)
  );

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state          <= conv_pkg::EPU_IDLE;
      len_q          <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      state          <= next_state;
      sample_valid_o <= rd_cs_o;  // sram read latency
      if (start_ok) len_q <= len_i;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      conv_pkg::EPU_IDLE: if (start_i) next_state = conv_pkg::FILL;
      conv_pkg::FILL:     if (rd_addr_o == conv_pkg::addr_t'(1)) next_state = conv_pkg::RUN;
      conv_pkg::RUN:      if (rd_last) next_state = conv_pkg::DRAIN;
      conv_pkg::DRAIN:    if (wr_cs_o && wr_last) next_state = conv_pkg::DONE;
      conv_pkg::DONE:     next_state = conv_pkg::EPU_IDLE;
      default:            next_state = conv_pkg::EPU_IDLE;
    endcase
  end

  assign rd_cs_o = (state == conv_pkg::FILL) || (state == conv_pkg::RUN);
  assign wr_cs_o = result_valid_i &&
                   ((state == conv_pkg::RUN) || (state == conv_pkg::DRAIN));
  assign done_o  = (state == conv_pkg::DONE);  // one-cycle pulse

endmodule

`default_nettype wire

//--- src/addr_counter.sv
`timescale 1ns/10ps
`default_nettype none

module addr_counter (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            clear_i,
  input  wire logic            step_i,
  input  wire conv_pkg::addr_t limit_i,
  output conv_pkg::addr_t      count_o,
  output logic                 last_o
);

  conv_pkg::addr_t limit_m1;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count_o <= '0;
    end else if (clear_i) begin
      count_o <= '0;
    end else if (step_i) begin
      count_o <= count_o + conv_pkg::addr_t'(1);
    end
  end

  // terminal at limit - 1
  assign limit_m1 = limit_i - conv_pkg::addr_t'(1);
  assign last_o   = (count_o == limit_m1);

endmodule

`default_nettype wire

//--- src/buffer_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module buffer_wrapper (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            enb_i,
  // host side
  input  wire logic            host_rd_req_i,
  input  wire logic            host_wr_req_i,
  input  wire logic            host_fin_i,
  input  wire logic            host_cs_i,
  input  wire logic            host_oe_i,
  input  wire conv_pkg::addr_t host_addr_i,
  input  wire conv_pkg::data_t host_wdata_i,
  output logic                 rvalid_o,
  output conv_pkg::data_t      rdata_o,
  // engine side
  input  wire logic            epu_cs_i,
  input  wire logic            epu_we_i,
  input  wire conv_pkg::addr_t epu_addr_i,
  input  wire conv_pkg::data_t epu_wdata_i,
  output conv_pkg::data_t      epu_rdata_o
);

  conv_pkg::wrap_state_t state, next_state;

  logic            sram_cs;
  logic            sram_we;
  conv_pkg::addr_t sram_addr;
  conv_pkg::data_t sram_wdata;
  conv_pkg::data_t sram_rdata;
  logic            rd_issued;

  buffer_sram u_sram (
    .clk     (clk),
    .cs_i    (sram_cs),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= conv_pkg::WRAP_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      conv_pkg::WRAP_IDLE, conv_pkg::EPU_RW: begin
        if (enb_i && host_rd_req_i) next_state = conv_pkg::HOST_RD;  // read wins
        else if (enb_i && host_wr_req_i) next_state = conv_pkg::HOST_WR;
      end
      conv_pkg::HOST_RD, conv_pkg::HOST_WR: begin
        if (enb_i && host_fin_i) next_state = conv_pkg::EPU_RW;  // hand to engine
      end
      default: next_state = conv_pkg::WRAP_IDLE;
    endcase
  end

  // sram port mux
  always_comb begin
    sram_cs    = 1'b0;
    sram_we    = 1'b0;
    sram_addr  = '0;
    sram_wdata = '0;
    case (state)
      conv_pkg::HOST_RD: begin
        sram_cs   = enb_i && host_cs_i && host_oe_i;
        sram_addr = host_addr_i;
      end
      conv_pkg::HOST_WR: begin
        sram_cs    = enb_i && host_cs_i;
        sram_we    = 1'b1;
        sram_addr  = host_addr_i;
        sram_wdata = host_wdata_i;
      end
      conv_pkg::EPU_RW: begin
        sram_cs    = epu_cs_i;
        sram_we    = epu_we_i;
        sram_addr  = epu_addr_i;
        sram_wdata = epu_wdata_i;
      end
      default: ;  // deselected
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_issued <= 1'b0;
    end else begin
      rd_issued <= (state == conv_pkg::HOST_RD) && sram_cs;
    end
  end

  assign rvalid_o    = rd_issued;
  assign rdata_o     = (state == conv_pkg::HOST_RD && rd_issued) ? sram_rdata : '0;
  assign epu_rdata_o = (state == conv_pkg::EPU_RW) ? sram_rdata : '0;

endmodule

`default_nettype wire

//--- src/buffer_sram.sv
`timescale 1ns/10ps
`default_nettype none

module buffer_sram (
  input  wire logic            clk,
  input  wire logic            cs_i,
  input  wire logic            we_i,
  input  wire conv_pkg::addr_t addr_i,
  input  wire conv_pkg::data_t wdata_i,
  output conv_pkg::data_t      rdata_o
);

  conv_pkg::data_t mem [conv_pkg::BUF_DEPTH];

  always_ff @(posedge clk) begin
    if (cs_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // one-cycle read latency
  always_ff @(posedge clk) begin
    if (cs_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- src/conv_pkg.sv
`default_nettype none

package conv_pkg;

  localparam int DATA_W   = 16;
  localparam int ADDR_W   = 10;
  localparam int WEIGHT_W = 8;
  localparam int ACC_W    = 32;

  localparam int BUF_DEPTH = 1024;   // words per buffer
  localparam int DATA_MAX  = 32767;  // saturation ceiling

  typedef logic signed [DATA_W-1:0]   data_t;    // sample or buffer word
  typedef logic        [ADDR_W-1:0]   addr_t;    // address and run length
  typedef logic signed [WEIGHT_W-1:0] weight_t;  // one tap
  typedef logic signed [ACC_W-1:0]    acc_t;     // product sum

  // buffer ownership
  typedef enum logic [1:0] {
    WRAP_IDLE = 2'd0,
    HOST_RD   = 2'd1,
    HOST_WR   = 2'd2,
    EPU_RW    = 2'd3
  } wrap_state_t;

  // run sequencer
  typedef enum logic [2:0] {
    EPU_IDLE = 3'd0,
    FILL     = 3'd1,
    RUN      = 3'd2,
    DRAIN    = 3'd3,
    DONE     = 3'd4
  } epu_state_t;

endpackage

`default_nettype wire
